/* verilog.f */
hw/bus_pkg.sv
hw/tick_timer.sv
hw/periodic_writer.sv
hw/bus_arbiter.sv
hw/peripheral_regs.sv
hw/hex_digit.sv
hw/bus_demo_top.sv
sim/bus_demo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the bus demo testbench with Verilator
set -e

cd "$(dirname "$0")"

TOP=bus_demo_tb
OBJ_DIR=obj_dir

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	-f verilog.f \
	--top-module "${TOP}" \
	-Mdir "${OBJ_DIR}" \
	-o "${TOP}"

# A $fatal in the testbench gives a failing exit status
"./${OBJ_DIR}/${TOP}"

/* sim/bus_demo_tb.sv */
`timescale 1ns/1ps

module bus_demo_tb import bus_pkg::*; ();

	// ==================================================
	// Test setup
	// ==================================================
	localparam int TIMER_WIDTH = 6;
	localparam int PHASE_B     = 1;
	// Timer period in cycles
	localparam int PERIOD       = 2 ** TIMER_WIDTH;
	localparam int RESET_CYCLES = 10;
	// Periods per stage
	localparam int LED_PERIODS      = 8;
	localparam int SHARED_PERIODS   = 8;
	localparam int UNMAPPED_PERIODS = 4;
	// 20 periods of 64 cycles plus reset, with margin
	localparam int TIMEOUT_CYCLES = 2000;

	localparam addr_t UNMAPPED_ADDR = 16'h0040;

	// Writer settings, shared by DUT and model
	localparam data_t               START_A = 32'h0000;
	localparam data_t               STEP_A  = 32'd1;
	localparam logic [BE_WIDTH-1:0] BE_A    = 4'b0011;
	localparam data_t               START_B = 32'h0400;
	localparam data_t               STEP_B  = 32'd2;
	localparam logic [BE_WIDTH-1:0] BE_B    = 4'b0011;

	logic                 CLOCK_50;
	logic                 rst_n;
	addr_t                addr_a;
	addr_t                addr_b;
	logic [LED_WIDTH-1:0] LEDR;
	logic [6:0]           HEX0;
	logic [6:0]           HEX1;
	logic [6:0]           HEX2;
	logic [6:0]           HEX3;

	// Reference model state
	data_t                value_a;
	data_t                value_b;
	logic [LED_WIDTH-1:0] led_model;
	logic [HEX_WIDTH-1:0] hex_model;
	int                   period_index;
	int                   cycle_count = 0;

	bus_demo_top #(
		.TIMER_WIDTH   (TIMER_WIDTH),
		.PHASE_B       (PHASE_B),
		.START_VALUE_A (START_A),
		.STEP_A        (STEP_A),
		.BYTE_ENABLE_A (BE_A),
		.START_VALUE_B (START_B),
		.STEP_B        (STEP_B),
		.BYTE_ENABLE_B (BE_B)
	) bus_demo_top_inst (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.addr_a   (addr_a),
		.addr_b   (addr_b),
		.LEDR     (LEDR),
		.HEX0     (HEX0),
		.HEX1     (HEX1),
		.HEX2     (HEX2),
		.HEX3     (HEX3)
	);

	// 40 ns clock
	initial begin
		CLOCK_50 = 1'b0;
		forever #20 CLOCK_50 = ~CLOCK_50;
	end

	// Run limit
	always @(posedge CLOCK_50) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Finished with errors");
			$fatal(1, "Timeout");
		end
	end

	// ==================================================
	// Reference model
	// ==================================================
	// Active low, segment a in bit 0
	function automatic logic [6:0] segment_pattern(input logic [3:0] digit);
		case (digit)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'ha: return 7'b0001000;
			4'hb: return 7'b0000011;
			4'hc: return 7'b1000110;
			4'hd: return 7'b0100001;
			4'he: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	// One bus write into the model registers
	// Unmapped addresses change nothing
	task automatic apply_write(input addr_t addr, input logic [BE_WIDTH-1:0] be,
			input data_t data);
		if (addr == LED_ADDR) begin
			if (be[0])
				led_model[7:0] = data[7:0];
			if (be[1])
				led_model[9:8] = data[9:8];
		end
		if (addr == HEX_ADDR) begin
			if (be[0])
				hex_model[7:0] = data[7:0];
			if (be[1])
				hex_model[15:8] = data[15:8];
		end
	endtask

	// Error line and fail message
	task automatic show_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		$display("Fail at %t: period %0d, %s is %h, expected %h",
			$time, period_index, what, got, expected);
		$display("Finished with errors");
	endtask

	// ==================================================
	// Checks
	// ==================================================
	task automatic check_outputs();
		logic [27:0] hex_seen;
		logic [27:0] hex_expected;
		hex_seen     = {HEX3, HEX2, HEX1, HEX0};
		hex_expected = {segment_pattern(hex_model[15:12]), segment_pattern(hex_model[11:8]),
			segment_pattern(hex_model[7:4]), segment_pattern(hex_model[3:0])};
		assert (LEDR == led_model) else begin
			show_mismatch("LEDR", 32'(LEDR), 32'(led_model));
			$fatal(1, "LEDR mismatch");
		end
		assert (hex_seen == hex_expected) else begin
			show_mismatch("HEX3..HEX0", 32'(hex_seen), 32'(hex_expected));
			$fatal(1, "HEX mismatch");
		end
	endtask

	// One timer period, addresses set before the writers latch them
	task automatic run_period(input addr_t next_a, input addr_t next_b);
		@(posedge CLOCK_50);
		addr_a <= next_a;
		addr_b <= next_b;
		// Writer a wins, so b's write lands last
		apply_write(next_a, BE_A, value_a);
		value_a = value_a + STEP_A;
		apply_write(next_b, BE_B, value_b);
		value_b = value_b + STEP_B;
		repeat (PERIOD - 1) @(posedge CLOCK_50);
		// Outputs settled well before the next fire
		@(negedge CLOCK_50);
		check_outputs();
		period_index = period_index + 1;
	endtask

	// ==================================================
	// Stimulus
	// ==================================================
	initial begin
		$timeformat(-9, 0, " ns", 12);
		rst_n        = 1'b0;
		addr_a       = LED_ADDR;
		addr_b       = HEX_ADDR;
		value_a      = START_A;
		value_b      = START_B;
		led_model    = '0;
		hex_model    = '0;
		period_index = 0;
		repeat (RESET_CYCLES) @(posedge CLOCK_50);
		rst_n <= 1'b1;
		// Cleared registers, digit 0 everywhere
		@(negedge CLOCK_50);
		check_outputs();
		// Separate targets
		repeat (LED_PERIODS) run_period(LED_ADDR, HEX_ADDR);
		// Both on HEX, LED frozen
		repeat (SHARED_PERIODS) run_period(HEX_ADDR, HEX_ADDR);
		// Writer a off the map
		repeat (UNMAPPED_PERIODS) run_period(UNMAPPED_ADDR, HEX_ADDR);
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* hw/bus_demo_top.sv */
`timescale 1ns/1ps

module bus_demo_top import bus_pkg::*; #(
	parameter int                  TIMER_WIDTH   = 25,
	parameter int                  PHASE_B       = 'h3fffff,
	parameter data_t               START_VALUE_A = 32'h0000,
	parameter data_t               STEP_A        = 32'd1,
	parameter logic [BE_WIDTH-1:0] BYTE_ENABLE_A = 4'b0011,
	parameter data_t               START_VALUE_B = 32'h0400,
	parameter data_t               STEP_B        = 32'd2,
	parameter logic [BE_WIDTH-1:0] BYTE_ENABLE_B = 4'b0011
) (
	input  logic                 CLOCK_50,
	input  logic                 rst_n,
	input  addr_t                addr_a,
	input  addr_t                addr_b,
	output logic [LED_WIDTH-1:0] LEDR,
	output logic [6:0]           HEX0,
	output logic [6:0]           HEX1,
	output logic [6:0]           HEX2,
	output logic [6:0]           HEX3
);

	logic                 fire_a;
	logic                 fire_b;
	bus_req_t             req_a;
	bus_req_t             req_b;
	bus_rsp_t             rsp_a;
	bus_rsp_t             rsp_b;
	// Arbitrated bus into the register block
	bus_req_t             slave_req;
	bus_rsp_t             slave_rsp;
	logic [HEX_WIDTH-1:0] hex_value;

	// ==================================================
	// Timer and bus masters
	// ==================================================
	tick_timer #(
		.TIMER_WIDTH (TIMER_WIDTH),
		.PHASE_B     (PHASE_B)
	) timer_inst (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.fire_a   (fire_a),
		.fire_b   (fire_b)
	);

	periodic_writer #(
		.START_VALUE (START_VALUE_A),
		.STEP        (STEP_A),
		.BYTE_ENABLE (BYTE_ENABLE_A)
	) writer_a (
		.CLOCK_50    (CLOCK_50),
		.rst_n       (rst_n),
		.fire        (fire_a),
		.target_addr (addr_a),
		.req         (req_a),
		.rsp         (rsp_a)
	);

	// Second master, fires later in the period
	periodic_writer #(
		.START_VALUE (START_VALUE_B),
		.STEP        (STEP_B),
		.BYTE_ENABLE (BYTE_ENABLE_B)
	) writer_b (
		.CLOCK_50    (CLOCK_50),
		.rst_n       (rst_n),
		.fire        (fire_b),
		.target_addr (addr_b),
		.req         (req_b),
		.rsp         (rsp_b)
	);

	// ==================================================
	// Arbiter and slave
	// ==================================================
	bus_arbiter arbiter_inst (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.req_a    (req_a),
		.req_b    (req_b),
		.req      (slave_req),
		.rsp      (slave_rsp),
		.rsp_a    (rsp_a),
		.rsp_b    (rsp_b)
	);

	peripheral_regs regs_inst (
		.CLOCK_50  (CLOCK_50),
		.rst_n     (rst_n),
		.req       (slave_req),
		.rsp       (slave_rsp),
		.leds      (LEDR),
		.hex_value (hex_value)
	);

	// Seven-segment decoders, HEX0 is the low nibble
	hex_digit digit0 (
		.value    (hex_value[3:0]),
		.segments (HEX0)
	);

	hex_digit digit1 (
		.value    (hex_value[7:4]),
		.segments (HEX1)
	);

	hex_digit digit2 (
		.value    (hex_value[11:8]),
		.segments (HEX2)
	);

	hex_digit digit3 (
		.value    (hex_value[15:12]),
		.segments (HEX3)
	);

endmodule

/* hw/hex_digit.sv */
`timescale 1ns/1ps

module hex_digit (
	input  logic [3:0] value,
	output logic [6:0] segments
);

	// Active low, bit 0 is segment a, bit 6 is segment g
	always_comb begin
		case (value)
			4'h0: segments = 7'b1000000;
			4'h1: segments = 7'b1111001;
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0010000;
			// Letters, lower case b and d
			4'ha: segments = 7'b0001000;
			4'hb: segments = 7'b0000011;
			4'hc: segments = 7'b1000110;
			4'hd: segments = 7'b0100001;
			4'he: segments = 7'b0000110;
			4'hf: segments = 7'b0001110;
			default: segments = 7'b1111111;
		endcase
	end

endmodule

/* hw/peripheral_regs.sv */
`timescale 1ns/1ps

module peripheral_regs import bus_pkg::*; (
	input  logic                 CLOCK_50,
	input  logic                 rst_n,
	input  bus_req_t             req,
	output bus_rsp_t             rsp,
	output logic [LED_WIDTH-1:0] leds,
	output logic [HEX_WIDTH-1:0] hex_value
);

	logic ack;
	// New write, not the tail of one already acked
	logic accept;
	logic hit_led;
	logic hit_hex;

	assign accept  = req.write && !ack;
	// Address decode
	assign hit_led = (req.addr == LED_ADDR);
	assign hit_hex = (req.addr == HEX_ADDR);

	// ==================================================
	// Ack generation
	// ==================================================
	// One-cycle pulse per accepted write
	// Unmapped addresses get acked too
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= accept;
		end
	end

	assign rsp.ack = ack;

	// ==================================================
	// Register writes
	// ==================================================
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			leds      <= '0;
			hex_value <= '0;
		end else if (accept) begin
			// LED register, 10 bits over lanes 0 and 1
			if (hit_led) begin
				if (req.byte_enable[0])
					leds[7:0] <= req.write_data[7:0];
				if (req.byte_enable[1])
					leds[9:8] <= req.write_data[9:8];
			end
			// HEX register, four nibbles over lanes 0 and 1
			if (hit_hex) begin
				if (req.byte_enable[0])
					hex_value[7:0] <= req.write_data[7:0];
				if (req.byte_enable[1])
					hex_value[15:8] <= req.write_data[15:8];
			end
		end
	end

endmodule

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter import bus_pkg::*; (
	input  logic     CLOCK_50,
	input  logic     rst_n,
	input  bus_req_t req_a,
	input  bus_req_t req_b,
	output bus_req_t req,
	input  bus_rsp_t rsp,
	output bus_rsp_t rsp_a,
	output bus_rsp_t rsp_b
);

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_A,
		OWN_B
	} owner_t;

	// Registered owner, held for the whole transaction
	owner_t owner;
	// Owner seen by the slave this cycle
	owner_t grant;

	// ==================================================
	// Grant selection
	// ==================================================
	// Fixed priority, a before b
	// New grant is combinational so the slave sees it at once
	always_comb begin
		grant = owner;
		if (owner == OWN_NONE) begin
			if (req_a.write) begin
				grant = OWN_A;
			end else if (req_b.write) begin
				grant = OWN_B;
			end
		end
	end

	// Release on the ack edge, otherwise keep the grant
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			owner <= OWN_NONE;
		end else if (rsp.ack) begin
			owner <= OWN_NONE;
		end else begin
			owner <= grant;
		end
	end

	// ==================================================
	// Request mux and ack routing
	// ==================================================
	always_comb begin
		case (grant)
			OWN_A:   req = req_a;
			OWN_B:   req = req_b;
			// Idle bus, no write
			default: req = '0;
		endcase
	end

	// Ack goes back to the owner only
	assign rsp_a.ack = rsp.ack && (owner == OWN_A);
	assign rsp_b.ack = rsp.ack && (owner == OWN_B);

endmodule

/* hw/periodic_writer.sv */
`timescale 1ns/1ps

module periodic_writer import bus_pkg::*; #(
	parameter data_t               START_VALUE = '0,
	parameter data_t               STEP        = 32'd1,
	parameter logic [BE_WIDTH-1:0] BYTE_ENABLE = 4'b0011
) (
	input  logic     CLOCK_50,
	input  logic     rst_n,
	input  logic     fire,
	input  addr_t    target_addr,
	output bus_req_t req,
	input  bus_rsp_t rsp
);

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} state_t;

	state_t state;
	// Stepping value, posted on every accepted fire
	data_t  value;
	// Latched request payload
	addr_t  addr_q;
	data_t  data_q;

	// ==================================================
	// Control FSM
	// ==================================================
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			value <= START_VALUE;
		end else begin
			case (state)
				ST_IDLE: begin
					// Fire only counts while idle
					if (fire) begin
						state <= ST_BUSY;
						value <= value + STEP;
					end
				end
				ST_BUSY: begin
					// Drop write on the ack edge
					if (rsp.ack) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Payload capture, value taken before the step
	always_ff @(posedge CLOCK_50) begin
		if (state == ST_IDLE && fire) begin
			addr_q <= target_addr;
			data_q <= value;
		end
	end

	// Write level follows the busy state
	assign req.write       = (state == ST_BUSY);
	assign req.addr        = addr_q;
	assign req.byte_enable = BYTE_ENABLE;
	assign req.write_data  = data_q;

endmodule

/* hw/tick_timer.sv */
`timescale 1ns/1ps

module tick_timer import bus_pkg::*; #(
	parameter int TIMER_WIDTH = 25,
	parameter int PHASE_B     = 'h3fffff
) (
	input  logic CLOCK_50,
	input  logic rst_n,
	output logic fire_a,
	output logic fire_b
);

	// Shared period counter, wraps every 2**TIMER_WIDTH cycles
	logic [TIMER_WIDTH-1:0] count;

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// ==================================================
	// Phase compare
	// ==================================================
	// Strobes come one cycle after the match
	// Writer a at the wrap point, writer b at its own phase
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			fire_a <= 1'b0;
			fire_b <= 1'b0;
		end else begin
			fire_a <= (count == '0);
			fire_b <= (count == TIMER_WIDTH'(PHASE_B));
		end
	end

endmodule

/* hw/bus_pkg.sv */
package bus_pkg;

	// ==================================================
	// Bus widths
	// ==================================================
	localparam int ADDR_WIDTH = 16;
	localparam int DATA_WIDTH = 32;
	localparam int BE_WIDTH   = 4;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;

	// One master's write request, held until ack
	typedef struct packed {
		logic                write;
		addr_t               addr;
		logic [BE_WIDTH-1:0] byte_enable;
		data_t               write_data;
	} bus_req_t;

	// Slave answer, ack is a single-cycle pulse
	typedef struct packed {
		logic ack;
	} bus_rsp_t;

	// ==================================================
	// Register map
	// ==================================================
	localparam addr_t LED_ADDR  = 16'h0000;
	localparam addr_t HEX_ADDR  = 16'h0020;
	localparam int    LED_WIDTH = 10;
	localparam int    HEX_WIDTH = 16;

endpackage
